// ==== logic/smem_bank.sv ====
// Wide byte-enabled single-ported memory with a one-slot read response register
`timescale 1ns/1ps

module smem_bank #(
    parameter int WORDS = 256
) (
    input  logic                clk,
    input  logic                reset,

    // Request channel
    input  logic                req_valid,
    output logic                req_ready,
    input  smem_pkg::wide_req_t req,

    // Response channel, loads only
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output smem_pkg::wide_rsp_t rsp
);
    import smem_pkg::*;

    // Only as many address bits as the depth needs
    localparam int IDX_BITS = (WORDS > 1) ? $clog2(WORDS) : 1;

    typedef logic [IDX_BITS-1:0] word_idx_t;
    typedef logic [7:0] byte_t;

    // The depth cannot exceed what the wide address can reach
    if (WORDS > (2 ** WIDE_ADDR_WIDTH)) begin : g_depth_check
        $error("smem_bank depth exceeds the wide address range");
    end

    // Storage is kept as bytes so that byte enables map one to one
    byte_t [WIDE_BYTES-1:0] mem [WORDS];

    word_idx_t req_idx;

    logic req_fire;
    logic wr_fire;
    logic rd_fire;
    logic rsp_fire;

    // Response slot
    logic rsp_valid_q;
    wide_data_t rsp_data_q;
    tag_t rsp_tag_q;

    // Low wide-address bits index the array
    assign req_idx = req.addr[IDX_BITS-1:0];

    assign req_fire = req_valid && req_ready;
    assign wr_fire = req_fire && req.rw;
    assign rd_fire = req_fire && !req.rw;
    assign rsp_fire = rsp_valid_q && rsp_ready;

    // The slot is free when empty or when it drains this cycle, so a new
    // request may follow directly behind a draining response
    assign req_ready = !rsp_valid_q || rsp_ready;

    // Stores write each byte under its enable
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < WIDE_BYTES; b++) begin
                if (req.byteen[b]) begin
                    mem[req_idx][b] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    // Load data and tag land in the slot on the accepting edge
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_data_q <= mem[req_idx];
            rsp_tag_q <= req.tag;
        end
    end

    // Valid flag of the response slot
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            if (rsp_fire) begin
                rsp_valid_q <= 1'b0;
            end
            // A read accepted on the draining edge refills the slot
            if (rd_fire) begin
                rsp_valid_q <= 1'b1;
            end
        end
    end

    assign rsp_valid = rsp_valid_q;

    always_comb begin
        rsp.data = rsp_data_q;
        rsp.tag = rsp_tag_q;
    end

endmodule

// ==== logic/smem_pkg.sv ====
// Shared widths, vector typedefs and narrow/wide request and response structs
package smem_pkg;

    // Narrow side is one requester word, wide side is one bank word
    localparam int NARROW_BYTES = 4;
    localparam int WIDE_BYTES = 16;
    localparam int LANES = WIDE_BYTES / NARROW_BYTES;
    localparam int LANE_BITS = $clog2(LANES);

    localparam int TAG_WIDTH = 4;

    // Addresses count narrow words on the requester side
    localparam int NARROW_ADDR_WIDTH = 10;
    localparam int WIDE_ADDR_WIDTH = NARROW_ADDR_WIDTH - LANE_BITS;

    localparam int NARROW_DATA_WIDTH = NARROW_BYTES * 8;
    localparam int WIDE_DATA_WIDTH = WIDE_BYTES * 8;

    typedef logic [NARROW_ADDR_WIDTH-1:0] narrow_addr_t;
    typedef logic [WIDE_ADDR_WIDTH-1:0] wide_addr_t;
    typedef logic [LANE_BITS-1:0] lane_idx_t;

    typedef logic [NARROW_DATA_WIDTH-1:0] narrow_data_t;
    typedef logic [NARROW_BYTES-1:0] narrow_byteen_t;
    typedef logic [WIDE_DATA_WIDTH-1:0] wide_data_t;
    typedef logic [WIDE_BYTES-1:0] wide_byteen_t;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Requester side request, rw set means store
    typedef struct packed {
        logic rw;
        narrow_addr_t addr;
        narrow_data_t data;
        narrow_byteen_t byteen;
        tag_t tag;
    } narrow_req_t;

    // Only loads produce a response
    typedef struct packed {
        narrow_data_t data;
        tag_t tag;
    } narrow_rsp_t;

    // Bank side request, data and byte enables cover all lanes
    typedef struct packed {
        logic rw;
        wide_addr_t addr;
        wide_data_t data;
        wide_byteen_t byteen;
        tag_t tag;
    } wide_req_t;

    typedef struct packed {
        wide_data_t data;
        tag_t tag;
    } wide_rsp_t;

endpackage

// ==== logic/smem_subsys.sv ====
// Shared-memory slice top level joining the narrow-to-wide adapter and the bank
`timescale 1ns/1ps

module smem_subsys #(
    parameter int WORDS = 64
) (
    input  logic                  clk,
    input  logic                  reset,

    // Narrow request channel from the requester
    input  logic                  req_valid,
    output logic                  req_ready,
    input  smem_pkg::narrow_req_t req,

    // Narrow response channel back to the requester
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output smem_pkg::narrow_rsp_t rsp
);
    import smem_pkg::*;

    // Wide channel between the adapter and the bank
    logic wide_req_valid;
    logic wide_req_ready;
    wide_req_t wide_req;

    logic wide_rsp_valid;
    logic wide_rsp_ready;
    wide_rsp_t wide_rsp;

    // Lane placement on the way in, lane selection on the way out
    smem_upsize u_upsize (
        .clk           (clk),
        .reset         (reset),
        .src_req_valid (req_valid),
        .src_req_ready (req_ready),
        .src_req       (req),
        .src_rsp_valid (rsp_valid),
        .src_rsp_ready (rsp_ready),
        .src_rsp       (rsp),
        .dst_req_valid (wide_req_valid),
        .dst_req_ready (wide_req_ready),
        .dst_req       (wide_req),
        .dst_rsp_valid (wide_rsp_valid),
        .dst_rsp_ready (wide_rsp_ready),
        .dst_rsp       (wide_rsp)
    );

    // Bank depth comes from this level
    smem_bank #(
        .WORDS (WORDS)
    ) u_bank (
        .clk       (clk),
        .reset     (reset),
        .req_valid (wide_req_valid),
        .req_ready (wide_req_ready),
        .req       (wide_req),
        .rsp_valid (wide_rsp_valid),
        .rsp_ready (wide_rsp_ready),
        .rsp       (wide_rsp)
    );

endmodule

// ==== logic/smem_upsize.sv ====
// Narrow-to-wide request adapter with lane placement and read-lane tracking
`timescale 1ns/1ps

module smem_upsize (
    input  logic                 clk,
    input  logic                 reset,

    // Narrow requester side
    input  logic                 src_req_valid,
    output logic                 src_req_ready,
    input  smem_pkg::narrow_req_t src_req,
    output logic                 src_rsp_valid,
    input  logic                 src_rsp_ready,
    output smem_pkg::narrow_rsp_t src_rsp,

    // Wide bank side
    output logic                 dst_req_valid,
    input  logic                 dst_req_ready,
    output smem_pkg::wide_req_t  dst_req,
    input  logic                 dst_rsp_valid,
    output logic                 dst_rsp_ready,
    input  smem_pkg::wide_rsp_t  dst_rsp
);
    import smem_pkg::*;

    // Low address bits pick the lane, the rest address the wide word
    lane_idx_t req_lane;
    wide_addr_t req_wide_addr;

    logic req_fire;
    logic rd_fire;
    logic rsp_fire;

    // Lane of the one outstanding read
    lane_idx_t rsp_lane_q;
    logic rsp_lane_valid_q;
    lane_idx_t rsp_lane;

    // Lane views of the wide data and byte enables
    narrow_data_t [LANES-1:0] wr_data_lanes;
    narrow_byteen_t [LANES-1:0] wr_byteen_lanes;
    narrow_data_t [LANES-1:0] rd_data_lanes;

    assign req_lane = src_req.addr[LANE_BITS-1:0];
    assign req_wide_addr = src_req.addr[NARROW_ADDR_WIDTH-1:LANE_BITS];

    assign req_fire = src_req_valid && src_req_ready;
    assign rd_fire = req_fire && !src_req.rw;
    assign rsp_fire = dst_rsp_valid && dst_rsp_ready;

    // Only the selected lane carries data and enables, other lanes stay zero
    always_comb begin
        wr_data_lanes = '0;
        wr_byteen_lanes = '0;
        wr_data_lanes[req_lane] = src_req.data;
        wr_byteen_lanes[req_lane] = src_req.byteen;
    end

    // Request path is purely combinational
    assign dst_req_valid = src_req_valid;
    assign src_req_ready = dst_req_ready;

    always_comb begin
        dst_req.rw = src_req.rw;
        dst_req.addr = req_wide_addr;
        dst_req.data = wr_data_lanes;
        dst_req.byteen = wr_byteen_lanes;
        dst_req.tag = src_req.tag;
    end

    // A read accepted on the same edge a response drains must keep its lane,
    // so the set takes priority over the clear
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_lane_q <= '0;
            rsp_lane_valid_q <= 1'b0;
        end else begin
            if (rsp_fire) begin
                rsp_lane_valid_q <= 1'b0;
            end
            if (rd_fire) begin
                rsp_lane_q <= req_lane;
                rsp_lane_valid_q <= 1'b1;
            end
        end
    end

    // Fall back to lane zero when no read is tracked
    assign rsp_lane = rsp_lane_valid_q ? rsp_lane_q : '0;

    assign rd_data_lanes = dst_rsp.data;

    // Response path passes straight through apart from lane selection
    assign src_rsp_valid = dst_rsp_valid;
    assign dst_rsp_ready = src_rsp_ready;

    always_comb begin
        src_rsp.data = rd_data_lanes[rsp_lane];
        src_rsp.tag = dst_rsp.tag;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module smem_tb \
    --Mdir "$OBJ_DIR" \
    -o smem_tb_sim \
    -f tb.f

# The log decides the result, so a fatal exit of the model is not an error here
"./$OBJ_DIR/smem_tb_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without reaching the end of the test"
    exit 1
fi

exit 0

// ==== tb.f ====
logic/smem_pkg.sv
logic/smem_upsize.sv
logic/smem_bank.sv
logic/smem_subsys.sv
verif/smem_subsys_sva.sv
verif/smem_tb.sv

// ==== verif/smem_subsys_sva.sv ====
// Bound assertions on handshake stability, the single outstanding read and reset state
`timescale 1ns/1ps

module smem_subsys_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  req_valid,
    input logic                  req_ready,
    input smem_pkg::narrow_req_t req,
    input logic                  rsp_valid,
    input logic                  rsp_ready,
    input smem_pkg::narrow_rsp_t rsp
);

    logic rd_accept;
    logic rsp_accept;
    logic read_pending;

    assign rd_accept = req_valid && req_ready && !req.rw;
    assign rsp_accept = rsp_valid && rsp_ready;

    // Tracks whether a read is waiting for its response
    always_ff @(posedge clk) begin
        if (reset) begin
            read_pending <= 1'b0;
        end else begin
            if (rsp_accept) begin
                read_pending <= 1'b0;
            end
            if (rd_accept) begin
                read_pending <= 1'b1;
            end
        end
    end

    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> $stable(req))
        else $error("Request changed while stalled");

    rsp_stable_a: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> $stable(rsp))
        else $error("Response changed while held");

    // A response draining on the same edge no longer counts as pending
    single_read_a: assert property (@(posedge clk) disable iff (reset)
        rd_accept |-> (!read_pending || rsp_accept))
        else $error("Read accepted while another read is outstanding");

    reset_rsp_a: assert property (@(posedge clk) reset |=> !rsp_valid)
        else $error("Response valid high after reset");

endmodule

bind smem_subsys smem_subsys_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

// ==== verif/smem_tb.sv ====
// Testbench for the shared-memory slice with byte-level reference model, compare tasks and timeout
`timescale 1ns/1ps

module smem_tb;
    import smem_pkg::*;

    localparam int WORDS = 64;
    localparam int NARROW_WORDS = WORDS * LANES;
    localparam int MODEL_BITS = $clog2(NARROW_WORDS);
    localparam int NUM_OPS = 600;
    // Four cycles per operation covers reads and response stalls with margin
    localparam int TIMEOUT_CYCLES = 4 * NUM_OPS + 200;

    logic clk;
    logic reset;
    logic req_valid;
    logic req_ready;
    narrow_req_t req;
    logic rsp_valid;
    logic rsp_ready;
    narrow_rsp_t rsp;

    // Byte image of the memory as the narrow side sees it
    logic [7:0] model_mem [NARROW_WORDS][NARROW_BYTES];

    narrow_rsp_t expected_q[$];
    narrow_rsp_t popped_rsp;
    narrow_rsp_t held_rsp;
    logic held;
    tag_t next_tag;
    int cycle_count = 0;

    smem_subsys #(
        .WORDS (WORDS)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compare_data(input string name, input narrow_data_t exp,
                                input narrow_data_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %h actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic compare_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %h actual %h",
                                     $time, name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s expected %b actual %b",
                                     $time, name, exp, act));
        end
    endtask

    task automatic check_no_unexpected();
        if (expected_q.size() == 0) begin
            report_failure($sformatf("A response arrived at %0t ns with no read outstanding",
                                     $time));
        end
    endtask

    // Expected load result built byte by byte from the model
    function automatic narrow_rsp_t expected_rsp(input narrow_addr_t addr, input tag_t tag);
        narrow_rsp_t r;
        for (int b = 0; b < NARROW_BYTES; b++) begin
            r.data[b*8 +: 8] = model_mem[addr[MODEL_BITS-1:0]][b];
        end
        r.tag = tag;
        return r;
    endfunction

    function automatic narrow_req_t make_req(input logic rw, input narrow_addr_t addr,
                                             input narrow_data_t data,
                                             input narrow_byteen_t byteen, input tag_t tag);
        narrow_req_t r;
        r.rw = rw;
        r.addr = addr;
        r.data = data;
        r.byteen = byteen;
        r.tag = tag;
        return r;
    endfunction

    function automatic narrow_addr_t random_addr();
        return narrow_addr_t'($urandom_range(0, NARROW_WORDS - 1));
    endfunction

    task automatic apply_store(input narrow_req_t r);
        for (int b = 0; b < NARROW_BYTES; b++) begin
            if (r.byteen[b]) begin
                model_mem[r.addr[MODEL_BITS-1:0]][b] = r.data[b*8 +: 8];
            end
        end
    endtask

    // Called just after a rising edge, returns just after the accepting edge
    task automatic send_request(input narrow_req_t r);
        logic accepted;
        accepted = 1'b0;
        req = r;
        req_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        if (r.rw) begin
            apply_store(r);
        end else begin
            expected_q.push_back(expected_rsp(r.addr, r.tag));
        end
    endtask

    task automatic wait_idle();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic store_word(input narrow_addr_t addr, input narrow_data_t data,
                              input narrow_byteen_t byteen);
        send_request(make_req(1'b1, addr, data, byteen, '0));
    endtask

    // One read at a time, with rsp_ready held low for a while if asked
    task automatic read_word(input narrow_addr_t addr, input int stall_cycles);
        narrow_req_t r;
        wait_idle();
        r = make_req(1'b0, addr, '0, '0, next_tag);
        next_tag++;
        if (stall_cycles > 0) begin
            rsp_ready = 1'b0;
        end
        send_request(r);
        repeat (stall_cycles) begin
            @(posedge clk);
            #1;
        end
        rsp_ready = 1'b1;
    endtask

    // Response checker, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            held = 1'b0;
        end else begin
            if (rsp_valid) begin
                check_no_unexpected();
            end
            // A read's response is due one cycle after acceptance and stays until it drains
            compare_flag("rsp_valid", expected_q.size() != 0, rsp_valid);
            compare_flag("req_ready", !(expected_q.size() != 0 && !rsp_ready), req_ready);
            if (held) begin
                compare_data("rsp.data held", held_rsp.data, rsp.data);
                compare_tag("rsp.tag held", held_rsp.tag, rsp.tag);
            end
            held = 1'b0;
            if (rsp_valid) begin
                if (rsp_ready) begin
                    popped_rsp = expected_q.pop_front();
                    compare_data("rsp.data", popped_rsp.data, rsp.data);
                    compare_tag("rsp.tag", popped_rsp.tag, rsp.tag);
                end else begin
                    held_rsp = rsp;
                    held = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    initial begin
        narrow_addr_t addr_v;
        narrow_addr_t base_v;
        narrow_byteen_t byteen_v;
        int stall_v;

        void'($urandom(33));
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        held = 1'b0;
        next_tag = '0;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle state straight after reset
        compare_flag("rsp_valid", 1'b0, rsp_valid);
        compare_flag("req_ready", 1'b1, req_ready);

        // Fill every lane of every wide word with full-word stores
        for (int a = 0; a < NARROW_WORDS; a++) begin
            store_word(narrow_addr_t'(a), narrow_data_t'($urandom()), 4'hf);
        end

        // Four lanes of a few wide words, sixteen reads walk all tag values
        for (int w = 0; w < WORDS; w += 21) begin
            for (int l = 0; l < LANES; l++) begin
                read_word(narrow_addr_t'(w * LANES + l), 0);
            end
        end

        // Partial stores, then the whole wide word is read back lane by lane
        for (int i = 0; i < 12; i++) begin
            addr_v = random_addr();
            byteen_v = narrow_byteen_t'($urandom_range(0, 15));
            store_word(addr_v, narrow_data_t'($urandom()), byteen_v);
            base_v = addr_v & ~narrow_addr_t'(LANES - 1);
            for (int l = 0; l < LANES; l++) begin
                read_word(base_v + narrow_addr_t'(l), 0);
            end
        end

        // Held responses with a store waiting behind them
        for (int i = 0; i < 8; i++) begin
            addr_v = random_addr();
            stall_v = int'($urandom_range(1, 6));
            wait_idle();
            rsp_ready = 1'b0;
            send_request(make_req(1'b0, addr_v, '0, '0, next_tag));
            next_tag++;
            fork
                store_word(random_addr(), narrow_data_t'($urandom()), 4'hf);
                begin
                    repeat (stall_v) begin
                        @(posedge clk);
                        #1;
                    end
                    rsp_ready = 1'b1;
                end
            join
        end

        // Random mix of stores and single outstanding reads
        for (int i = 0; i < NUM_OPS; i++) begin
            addr_v = random_addr();
            if ($urandom_range(0, 1) == 0) begin
                byteen_v = ($urandom_range(0, 1) == 0) ? 4'hf
                                                      : narrow_byteen_t'($urandom_range(0, 15));
                store_word(addr_v, narrow_data_t'($urandom()), byteen_v);
            end else begin
                stall_v = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
                read_word(addr_v, stall_v);
            end
        end

        wait_idle();
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        if (expected_q.size() != 0 || rsp_valid) begin
            report_failure("Responses remain outstanding at the end of the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
